//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_icache \
  -Mdir "$BUILD" -o sim_icache
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD/sim_icache" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

exit 0

//--- sim/icache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic ready_i,
  input logic valid_i,
  input logic miss_i,
  input logic mem_req_i,
  input logic mem_rtrn_vld_i
);

  // one line request in flight
  logic outstanding_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_i) begin
      outstanding_q <= 1'b1;
    end else if (mem_rtrn_vld_i) begin
      outstanding_q <= 1'b0;
    end
  end

  //////////////////////////////
  // memory side
  //////////////////////////////

  no_second_req: assert property (@(posedge clk_i) disable iff (rst_i)
    outstanding_q |-> !mem_req_i)
    else $error("memory request issued while another is outstanding");

  //////////////////////////////
  // fetch side
  //////////////////////////////

  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> (!valid_i && !miss_i && !mem_req_i && ready_i))
    else $error("outputs not idle after reset");

  // stall from the miss strobe until the line is back
  stall_on_miss: assert property (@(posedge clk_i) disable iff (rst_i)
    (miss_i || outstanding_q) |-> !ready_i)
    else $error("ready_o high while a miss is outstanding");

endmodule

bind icache_top icache_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .ready_i        (ready_o),
  .valid_i        (valid_o),
  .miss_i         (miss_o),
  .mem_req_i      (mem_req_o),
  .mem_rtrn_vld_i (mem_rtrn_vld_i)
);

`default_nettype wire

//--- sim/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tb_icache import fetch_pkg::*; ();

  //////////////////////////////
  // constants
  //////////////////////////////

  localparam int     CLK_HALF    = 50;
  localparam int     DRIVE_DLY   = 1;
  localparam int     SETS        = `ICACHE_SETS;
  localparam int     LINE_BYTES  = `ICACHE_LINE_WORDS * 4;
  localparam int     LINE_BITS   = `ICACHE_LINE_WORDS * 32;
  localparam vaddr_t NC_BASE     = `ICACHE_NC_BASE;
  // modeled memory is 64 KiB
  localparam vaddr_t MEM_BYTES   = 32'h0001_0000;
  localparam int     MAX_ROWS    = 256;
  localparam int     RAND_ROWS   = 64;
  localparam int     MAX_MEM_DLY = 8;
  // request, memory wait, deliver, output and slack
  localparam int     MISS_CYCLES = MAX_MEM_DLY + 6;
  localparam int     TIMEOUT_PAD = 200;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic   clk_i = 1'b0;
  logic   rst_i;
  logic   en_i;
  logic   flush_i;
  logic   req_i;
  logic   kill_i;
  vaddr_t vaddr_i;
  logic   ready_o;
  logic   valid_o;
  vaddr_t vaddr_o;
  instr_t data_o;
  logic   miss_o;
  logic   mem_req_o;
  vaddr_t mem_addr_o;
  logic   mem_rtrn_vld_i;
  logic [LINE_BITS-1:0] mem_rtrn_data_i;

  // vector table
  // expected columns come from the reference model
  string  tab_name  [MAX_ROWS];
  logic   tab_en    [MAX_ROWS];
  vaddr_t tab_addr  [MAX_ROWS];
  logic   tab_kill  [MAX_ROWS];
  logic   tab_flush [MAX_ROWS];
  logic   tab_miss  [MAX_ROWS];
  instr_t tab_data  [MAX_ROWS];
  int     n_rows = 0;
  logic   table_ready = 1'b0;

  // direct-mapped tag model
  logic   mdl_valid [SETS];
  vaddr_t mdl_tag   [SETS];

  // rows in flight and the cycle valid_o is due
  // -1 marks a miss
  int     exp_row_q [$];
  int     exp_cyc_q [$];
  int     exp_misses = 0;
  int     miss_seen = 0;
  int     cyc = 0;
  int     rtrn_cyc = 0;

  always #CLK_HALF clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  icache_top dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .kill_i          (kill_i),
    .vaddr_i         (vaddr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .vaddr_o         (vaddr_o),
    .data_o          (data_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i)
  );

  //////////////////////////////
  // checking helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (expected === actual) else begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // miss, memory request and ready in the cycle after acceptance
  // refill is idle whenever a request was accepted
  task automatic check_lookup_cycle(input int r);
    logic stall;
    stall = tab_miss[r] || tab_flush[r];
    expect_equal({tab_name[r], " miss"}, 32'(tab_miss[r]), 32'(miss_o));
    expect_equal({tab_name[r], " mem_req"}, 32'(tab_miss[r]), 32'(mem_req_o));
    expect_equal({tab_name[r], " ready"}, 32'(!stall), 32'(ready_o));
    if (tab_miss[r]) begin
      expect_equal({tab_name[r], " mem_addr"}, (tab_addr[r] / LINE_BYTES) * LINE_BYTES,
                   mem_addr_o);
    end
  endtask

  //////////////////////////////
  // reference model and table
  //////////////////////////////

  task automatic add_vector(input string name, input logic en, input vaddr_t addr,
                            input logic kill, input logic flush);
    int     idx;
    vaddr_t tag;
    logic   cacheable;
    logic   miss;
    idx       = (addr / LINE_BYTES) % SETS;
    tag       = addr / (LINE_BYTES * SETS);
    cacheable = en && (addr < NC_BASE);
    miss      = 1'b0;
    // killed or flushed rows never look up
    if (!kill && !flush) begin
      miss = !(cacheable && mdl_valid[idx] && mdl_tag[idx] == tag);
      if (miss && cacheable) begin
        mdl_valid[idx] = 1'b1;
        mdl_tag[idx]   = tag;
      end
    end
    if (flush) begin
      for (int s = 0; s < SETS; s++) begin
        mdl_valid[s] = 1'b0;
      end
    end
    if (miss) begin
      exp_misses++;
    end
    tab_name[n_rows]  = name;
    tab_en[n_rows]    = en;
    tab_addr[n_rows]  = addr;
    tab_kill[n_rows]  = kill;
    tab_flush[n_rows] = flush;
    tab_miss[n_rows]  = miss;
    // every memory word holds its own byte address
    tab_data[n_rows]  = addr;
    n_rows++;
  endtask

  task automatic build_vectors();
    vaddr_t a;
    for (int s = 0; s < SETS; s++) begin
      mdl_valid[s] = 1'b0;
    end
    // eight lines cold, then the same eight warm
    for (int k = 0; k < 32; k++) begin
      add_vector("cold_sweep", 1'b1, 32'(k * 4), 1'b0, 1'b0);
    end
    for (int k = 0; k < 32; k++) begin
      add_vector("warm_sweep", 1'b1, 32'(k * 4), 1'b0, 1'b0);
    end
    // cached lines, cache off
    for (int k = 0; k < 4; k++) begin
      add_vector("disabled", 1'b0, 32'h10 + 32'(k * 4), 1'b0, 1'b0);
    end
    // uncached region never allocates
    add_vector("uncached", 1'b1, NC_BASE, 1'b0, 1'b0);
    add_vector("uncached", 1'b1, NC_BASE + 32'h4, 1'b0, 1'b0);
    add_vector("uncached", 1'b0, NC_BASE + 32'h40, 1'b0, 1'b0);
    add_vector("uncached", 1'b1, NC_BASE, 1'b0, 1'b0);
    // kill a miss, then a hit
    add_vector("kill", 1'b1, 32'h100, 1'b1, 1'b0);
    add_vector("kill", 1'b1, 32'h104, 1'b0, 1'b0);
    add_vector("kill", 1'b1, 32'h108, 1'b1, 1'b0);
    add_vector("kill", 1'b1, 32'h10c, 1'b0, 1'b0);
    add_vector("kill", 1'b1, 32'h000, 1'b1, 1'b0);
    add_vector("kill", 1'b1, 32'h004, 0, 1'b0);
    // flush drops its own request and all lines
    add_vector("flush", 1'b1, 32'h020, 1'b0, 1'b1);
    add_vector("flush", 1'b1, 32'h020, 1'b0, 1'b0);
    add_vector("flush", 1'b1, 32'h024, 1'b0, 1'b0);
    add_vector("flush", 1'b1, 32'h104, 1'b0, 1'b0);
    // 32 lines over 16 sets plus a few uncached words
    for (int k = 0; k < RAND_ROWS; k++) begin
      if ($urandom_range(0, 7) == 0) begin
        a = NC_BASE + 32'($urandom_range(0, 15) * 4);
      end else begin
        a = 32'($urandom_range(0, 127) * 4);
      end
      add_vector("random", $urandom_range(0, 9) != 0, a, $urandom_range(0, 9) == 0,
                 $urandom_range(0, 31) == 0);
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive_vectors();
    int   i;
    int   last;
    logic acc;
    logic pend;
    i    = 0;
    last = 0;
    pend = 1'b0;
    while (i < n_rows) begin
      // en_i stays put while the previous row is in lookup
      if (pend && tab_en[i] != en_i) begin
        req_i = 1'b0;
      end else begin
        req_i   = 1'b1;
        en_i    = tab_en[i];
        vaddr_i = tab_addr[i];
      end
      @(negedge clk_i);
      acc = req_i & ready_o;
      if (pend) begin
        check_lookup_cycle(last);
      end
      pend = 1'b0;
      @(posedge clk_i);
      #DRIVE_DLY;
      req_i   = 1'b0;
      kill_i  = 1'b0;
      flush_i = 1'b0;
      if (acc) begin
        // kill and flush act in the lookup cycle
        kill_i  = tab_kill[i];
        flush_i = tab_flush[i];
        if (!tab_kill[i] && !tab_flush[i]) begin
          exp_row_q.push_back(i);
          exp_cyc_q.push_back(tab_miss[i] ? -1 : cyc + 1);
        end
        last = i;
        pend = 1'b1;
        i++;
      end
    end
    @(negedge clk_i);
    if (pend) begin
      check_lookup_cycle(last);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    kill_i  = 1'b0;
    flush_i = 1'b0;
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  initial begin : mem_model
    vaddr_t base;
    int     delay;
    logic [LINE_BITS-1:0] line;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (!rst_i && mem_req_o) begin
        base = mem_addr_o;
        if (base >= MEM_BYTES) begin
          abort_run("memory request outside the modeled memory");
        end else begin
          delay = $urandom_range(1, MAX_MEM_DLY);
          for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
            line[k*32 +: 32] = base + 32'(k * 4);
          end
          // first wait edge is the request edge itself
          repeat (delay) @(posedge clk_i);
          #DRIVE_DLY;
          mem_rtrn_vld_i  = 1'b1;
          mem_rtrn_data_i = line;
          rtrn_cyc        = cyc;
          @(posedge clk_i);
          #DRIVE_DLY;
          mem_rtrn_vld_i  = 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // result and miss monitors
  //////////////////////////////

  always @(negedge clk_i) begin : result_check
    int r;
    int want;
    if (!rst_i && valid_o) begin
      if (exp_row_q.size() == 0) begin
        abort_run("valid_o pulsed with no request outstanding");
      end else begin
        r    = exp_row_q.pop_front();
        want = exp_cyc_q.pop_front();
        // a miss result lands two edges after the return edge
        // and the stall ends with it
        if (want < 0) begin
          want = rtrn_cyc + 2;
          expect_equal({tab_name[r], " ready"}, 32'd1, 32'(ready_o));
        end
        expect_equal({tab_name[r], " vaddr"}, tab_addr[r], vaddr_o);
        expect_equal({tab_name[r], " data"}, tab_data[r], data_o);
        expect_equal({tab_name[r], " latency"}, want, cyc);
      end
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && miss_o) begin
      miss_seen <= miss_seen + 1;
    end
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (n_rows * MISS_CYCLES + TIMEOUT_PAD) @(posedge clk_i);
    abort_run("timeout, the DUT stopped returning results");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(43117));
    rst_i   = 1'b1;
    en_i    = 1'b1;
    flush_i = 1'b0;
    req_i   = 1'b0;
    kill_i  = 1'b0;
    vaddr_i = '0;
    build_vectors();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    drive_vectors();
    while (exp_row_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    expect_equal("miss_count", 32'(exp_misses), 32'(miss_seen));
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

`include "icache_params.svh"

package fetch_pkg;

  // one instruction word
  localparam int unsigned INSTR_W = 32;

  // byte address as seen by the fetch unit
  // no translation, so this is also the physical address
  typedef logic [`ICACHE_VADDR_W-1:0] vaddr_t;

  // fetched instruction
  typedef logic [INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

//--- source/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   flush_i,
  // read port, data one cycle later
  input  index_t rd_index_i,
  output tag_t   rd_tag_o,
  output logic   rd_valid_o,
  output line_t  rd_line_o,
  // line write from refill
  input  logic   wr_en_i,
  input  index_t wr_index_i,
  input  tag_t   wr_tag_i,
  input  line_t  wr_line_i
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // tag and data arrays
  tag_t  tag_mem  [NUM_SETS];
  line_t line_mem [NUM_SETS];

  // one valid flag per set
  // kept in flops so flush can clear all at once
  logic [NUM_SETS-1:0] valid_q;

  //////////////////////////////
  // tag and data
  //////////////////////////////

  // write first in code, but nonblocking
  // so a same-set read still gets the old entry
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i]  <= wr_tag_i;
      line_mem[wr_index_i] <= wr_line_i;
    end
    rd_tag_o  <= tag_mem[rd_index_i];
    rd_line_o <= line_mem[rd_index_i];
  end

  //////////////////////////////
  // valid bits
  //////////////////////////////

  // flush beats a write in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_index_i] <= 1'b1;
    end
  end

  // registered like the tag read
  // old value on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= valid_q[rd_index_i];
    end
  end

endmodule

`default_nettype wire

//--- source/icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup import fetch_pkg::*; import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   en_i,
  input  logic   flush_i,
  // fetch request
  input  logic   req_i,
  input  logic   kill_i,
  input  vaddr_t vaddr_i,
  output logic   ready_o,
  // fetch response
  output logic   valid_o,
  output vaddr_t vaddr_o,
  output instr_t data_o,
  // array read port
  output index_t rd_index_o,
  input  tag_t   rd_tag_i,
  input  logic   rd_valid_i,
  input  line_t  rd_line_i,
  // miss to refill
  output logic   miss_o,
  output vaddr_t miss_vaddr_o,
  input  logic   refill_busy_i,
  // line coming back from refill
  input  logic   fill_vld_i,
  input  vaddr_t fill_vaddr_i,
  input  line_t  fill_line_i
);

  //////////////////////////////
  // declarations
  //////////////////////////////

  // request handshake
  logic   accept;

  // lookup stage
  logic   s1_vld_q;
  vaddr_t s1_vaddr_q;
  logic   s1_live;
  logic   tag_match;
  logic   hit;

  // output register
  logic   valid_q;
  vaddr_t vaddr_q;
  instr_t data_q;

  //////////////////////////////
  // request stage
  //////////////////////////////

  // hold off while a miss is open or being raised
  // flush also blocks, the array is being cleared
  assign ready_o = ~(refill_busy_i | miss_o | flush_i);
  assign accept  = req_i & ready_o;

  // array read starts right at acceptance
  // index taken straight from the incoming address
  assign rd_index_o = addr_index(vaddr_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_vaddr_q <= vaddr_i;
    end
  end

  //////////////////////////////
  // tag compare
  //////////////////////////////

  // kill and flush drop the request here
  assign s1_live = s1_vld_q & ~kill_i & ~flush_i;

  assign tag_match = rd_valid_i & (rd_tag_i == addr_tag(s1_vaddr_q));

  // disabled cache and uncached region never hit
  assign hit = s1_live & tag_match & en_i & addr_cacheable(s1_vaddr_q);

  // anything else that survived goes to memory
  assign miss_o       = s1_live & ~hit;
  assign miss_vaddr_o = s1_vaddr_q;

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= hit | fill_vld_i;
    end
  end

  // a fill and a hit never meet
  // ready stays low until the fill is out
  always_ff @(posedge clk_i) begin
    if (fill_vld_i) begin
      vaddr_q <= fill_vaddr_i;
      data_q  <= line_word(fill_line_i, addr_offset(fill_vaddr_i));
    end else if (hit) begin
      vaddr_q <= s1_vaddr_q;
      data_q  <= line_word(rd_line_i, addr_offset(s1_vaddr_q));
    end
  end

  assign valid_o = valid_q;
  assign vaddr_o = vaddr_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- source/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address width in bits
`define ICACHE_VADDR_W 32

// 32-bit words per cache line
`define ICACHE_LINE_WORDS 4

// number of sets
// must be a power of two
`define ICACHE_SETS 16

// first uncached byte address
// everything above goes straight to memory
`define ICACHE_NC_BASE 32'h0000_8000

`endif

//--- source/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  localparam int unsigned WORD_W     = 32;
  localparam int unsigned NUM_SETS   = `ICACHE_SETS;
  localparam int unsigned BYTE_OFF_W = $clog2(WORD_W / 8);
  localparam int unsigned OFFSET_W   = $clog2(`ICACHE_LINE_WORDS);
  localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
  localparam int unsigned LINE_OFF_W = BYTE_OFF_W + OFFSET_W;
  localparam int unsigned TAG_W      = `ICACHE_VADDR_W - INDEX_W - LINE_OFF_W;
  localparam int unsigned LINE_W     = `ICACHE_LINE_WORDS * WORD_W;

  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  // word 0 sits in the low bits
  typedef logic [LINE_W-1:0]   line_t;

  // refill sequencer
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    DELIVER
  } refill_state_t;

  //////////////////////////////
  // address fields
  //////////////////////////////

  function automatic index_t addr_index(input logic [`ICACHE_VADDR_W-1:0] addr);
    return addr[LINE_OFF_W +: INDEX_W];
  endfunction

  function automatic tag_t addr_tag(input logic [`ICACHE_VADDR_W-1:0] addr);
    return addr[`ICACHE_VADDR_W-1 -: TAG_W];
  endfunction

  function automatic offset_t addr_offset(input logic [`ICACHE_VADDR_W-1:0] addr);
    return addr[BYTE_OFF_W +: OFFSET_W];
  endfunction

  // strip the offset bits for a line request
  function automatic logic [`ICACHE_VADDR_W-1:0] line_base(
    input logic [`ICACHE_VADDR_W-1:0] addr
  );
    return {addr[`ICACHE_VADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  endfunction

  // below the uncached boundary
  function automatic logic addr_cacheable(input logic [`ICACHE_VADDR_W-1:0] addr);
    return addr < `ICACHE_NC_BASE;
  endfunction

  // pick one 32-bit word out of a line
  function automatic logic [WORD_W-1:0] line_word(input line_t line, input offset_t off);
    return line[off*WORD_W +: WORD_W];
  endfunction

endpackage

`default_nettype wire

//--- source/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill import fetch_pkg::*; import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   en_i,
  input  logic   flush_i,
  // miss from lookup
  input  logic   miss_i,
  input  vaddr_t miss_vaddr_i,
  output logic   busy_o,
  // memory side
  output logic   mem_req_o,
  output vaddr_t mem_addr_o,
  input  logic   mem_rtrn_vld_i,
  input  line_t  mem_rtrn_data_i,
  // array write port
  output logic   wr_en_o,
  output index_t wr_index_o,
  output tag_t   wr_tag_o,
  output line_t  wr_line_o,
  // line back to lookup
  output logic   fill_vld_o,
  output vaddr_t fill_vaddr_o,
  output line_t  fill_line_o
);

  //////////////////////////////
  // declarations
  //////////////////////////////

  refill_state_t state_q;
  refill_state_t state_d;

  // set by a flush while the line is in flight
  logic   discard_q;
  // line goes into the array when it returns
  logic   alloc_q;

  // captured miss
  vaddr_t vaddr_q;
  line_t  line_q;

  logic   issue;
  logic   waiting;

  //////////////////////////////
  // sequencer
  //////////////////////////////

  // request leaves in the miss cycle itself
  assign issue   = (state_q == IDLE) & miss_i;
  // REQ is the first cycle after the request
  // memory may already answer there
  assign waiting = (state_q == REQ) | (state_q == WAIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss_i) begin
          state_d = REQ;
        end
      end
      REQ, WAIT: begin
        if (mem_rtrn_vld_i) begin
          state_d = DELIVER;
        end else begin
          state_d = WAIT;
        end
      end
      DELIVER: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      discard_q <= 1'b0;
      alloc_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (issue) begin
        discard_q <= 1'b0;
        alloc_q   <= en_i & addr_cacheable(miss_vaddr_i);
      end else if (waiting && flush_i) begin
        discard_q <= 1'b1;
      end
    end
  end

  // miss address and returned line
  always_ff @(posedge clk_i) begin
    if (issue) begin
      vaddr_q <= miss_vaddr_i;
    end
    if (waiting && mem_rtrn_vld_i) begin
      line_q <= mem_rtrn_data_i;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign busy_o     = (state_q != IDLE);
  assign mem_req_o  = issue;
  assign mem_addr_o = line_base(miss_vaddr_i);

  // a flush in DELIVER itself is handled by the array
  assign wr_en_o    = (state_q == DELIVER) & alloc_q & ~discard_q;
  assign wr_index_o = addr_index(vaddr_q);
  assign wr_tag_o   = addr_tag(vaddr_q);
  assign wr_line_o  = line_q;

  // no result once a flush has been seen
  assign fill_vld_o   = (state_q == DELIVER) & ~discard_q & ~flush_i;
  assign fill_vaddr_o = vaddr_q;
  assign fill_line_o  = line_q;

endmodule

`default_nettype wire

//--- source/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import fetch_pkg::*; import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   en_i,
  input  logic   flush_i,
  // fetch side
  input  logic   req_i,
  input  logic   kill_i,
  input  vaddr_t vaddr_i,
  output logic   ready_o,
  output logic   valid_o,
  output vaddr_t vaddr_o,
  output instr_t data_o,
  output logic   miss_o,
  // memory side
  output logic   mem_req_o,
  output vaddr_t mem_addr_o,
  input  logic   mem_rtrn_vld_i,
  input  line_t  mem_rtrn_data_i
);

  //////////////////////////////
  // internal wires
  //////////////////////////////

  // array read
  index_t rd_index;
  tag_t   rd_tag;
  logic   rd_valid;
  line_t  rd_line;

  // array write
  logic   wr_en;
  index_t wr_index;
  tag_t   wr_tag;
  line_t  wr_line;

  // lookup to refill and back
  vaddr_t miss_vaddr;
  logic   refill_busy;
  logic   fill_vld;
  vaddr_t fill_vaddr;
  line_t  fill_line;

  //////////////////////////////
  // lookup stage
  //////////////////////////////

  icache_lookup u_lookup (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .req_i         (req_i),
    .kill_i        (kill_i),
    .vaddr_i       (vaddr_i),
    .ready_o       (ready_o),
    .valid_o       (valid_o),
    .vaddr_o       (vaddr_o),
    .data_o        (data_o),
    .rd_index_o    (rd_index),
    .rd_tag_i      (rd_tag),
    .rd_valid_i    (rd_valid),
    .rd_line_i     (rd_line),
    .miss_o        (miss_o),
    .miss_vaddr_o  (miss_vaddr),
    .refill_busy_i (refill_busy),
    .fill_vld_i    (fill_vld),
    .fill_vaddr_i  (fill_vaddr),
    .fill_line_i   (fill_line)
  );

  //////////////////////////////
  // tag and data array
  //////////////////////////////

  icache_array u_array (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .rd_index_i (rd_index),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .rd_line_o  (rd_line),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_tag_i   (wr_tag),
    .wr_line_i  (wr_line)
  );

  //////////////////////////////
  // refill unit
  //////////////////////////////

  // miss strobe is shared with the fetch port
  icache_refill u_refill (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .miss_i          (miss_o),
    .miss_vaddr_i    (miss_vaddr),
    .busy_o          (refill_busy),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .wr_en_o         (wr_en),
    .wr_index_o      (wr_index),
    .wr_tag_o        (wr_tag),
    .wr_line_o       (wr_line),
    .fill_vld_o      (fill_vld),
    .fill_vaddr_o    (fill_vaddr),
    .fill_line_o     (fill_line)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/fetch_pkg.sv
source/icache_pkg.sv
source/icache_array.sv
source/icache_lookup.sv
source/icache_refill.sv
source/icache_top.sv
sim/icache_asserts.sv
sim/tb_icache.sv
